//--- baser_block_decoder.sv
// Needs a block on every clock and does no block-lock or sequence checking of its own
`timescale 1ns/10ps
`default_nettype none
`include "baser_rx_macros.svh"

module baser_block_decoder (
    input  wire logic                        clk,
    input  wire logic                        reset_crc,
    input  wire logic [`BASER_DATA_W-1:0]    encoded_rx_data,
    input  wire baser_coding_pkg::sync_hdr_t encoded_rx_hdr,
    output logic [`BASER_DATA_W-1:0]         lane_data,
    output baser_frame_pkg::lane_type_t      lane_type,
    output logic [1:0]                       start_packet,
    output logic                             rx_bad_block
);
    import baser_coding_pkg::*;
    import baser_frame_pkg::*;

    localparam int HALF_W = `BASER_DATA_W / 2;

    block_type_t              btype;
    logic [2:0]               term_n;
    logic                     is_data;
    logic                     is_term;
    logic                     is_start0;
    logic                     is_start4;
    logic                     is_idle_ctrl;
    logic [`BASER_DATA_W-1:0] masked;

    logic                     lanes_swapped;
    logic [HALF_W-1:0]        swap_data;  // Upper half of the previous block
    logic                     delay_type_valid;
    lane_type_t               delay_type;

    logic                     swapped_next;
    logic                     delay_valid_next;
    lane_type_t               delay_type_next;
    lane_type_t               type_next;
    logic                     bad_next;
    logic [`BASER_DATA_W-1:0] data_next;

    always_comb begin
        btype        = block_type_t'(encoded_rx_data[7:0]);
        term_n       = encoded_rx_data[6:4];  // Data bytes ahead of a terminate
        is_data      = encoded_rx_hdr == SYNC_DATA;
        is_term      = 1'b0;
        is_start0    = 1'b0;
        is_start4    = 1'b0;
        is_idle_ctrl = 1'b0;
        if (encoded_rx_hdr == SYNC_CTRL) begin
            case (btype)
                BT_START_0:                          is_start0 = 1'b1;
                BT_START_4, BT_OS_START:             is_start4 = 1'b1;
                BT_CTRL, BT_OS_4, BT_OS_04, BT_OS_0: is_idle_ctrl = 1'b1;
                BT_TERM_0, BT_TERM_1, BT_TERM_2, BT_TERM_3,
                BT_TERM_4, BT_TERM_5, BT_TERM_6, BT_TERM_7: is_term = 1'b1;
                default: ;
            endcase
        end
        // Terminate data starts after the type byte, trailing control bytes read as zero
        masked = encoded_rx_data;
        if (is_term) begin
            masked = (encoded_rx_data >> 8) & ~({`BASER_DATA_W{1'b1}} << (8 * term_n));
        end
    end

    always_comb begin
        swapped_next     = lanes_swapped;
        delay_valid_next = 1'b0;
        delay_type_next  = is_start4 ? LT_START : lane_type_t'({2'b10, term_n[1:0]});
        bad_next         = !(is_data || is_term || is_start0 || is_start4 || is_idle_ctrl);
        data_next        = masked;
        if (is_data) begin
            type_next = LT_DATA;
        end else if (is_term) begin
            type_next = lane_type_t'({1'b1, term_n});
        end else if (bad_next) begin
            type_next = LT_ERROR;
        end else begin
            type_next = LT_IDLE;
        end

        if (is_start0) begin
            swapped_next = 1'b0;
            type_next    = LT_START;
        end else if (is_start4) begin
            swapped_next     = 1'b1;
            delay_valid_next = 1'b1;  // Aligned start shows up with the next block
            type_next        = delay_type_valid ? delay_type : LT_IDLE;
            data_next        = {masked[HALF_W-1:0], swap_data};
        end else if (lanes_swapped) begin
            data_next = {masked[HALF_W-1:0], swap_data};
            if (is_term && term_n[2]) begin
                delay_valid_next = 1'b1;  // Terminate lands in the next aligned word
                type_next        = LT_DATA;
            end else if (is_term) begin
                type_next = lane_type_t'({2'b11, term_n[1:0]});
            end
            if (delay_type_valid) begin
                type_next = delay_type;
                data_next = {{HALF_W{1'b0}}, swap_data};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            lane_type        <= LT_IDLE;
            lanes_swapped    <= 1'b0;
            delay_type_valid <= 1'b0;
            delay_type       <= LT_IDLE;
            start_packet     <= 2'b00;
            rx_bad_block     <= 1'b0;
        end else begin
            lane_type        <= type_next;
            lanes_swapped    <= swapped_next;
            delay_type_valid <= delay_valid_next;
            delay_type       <= delay_type_next;
            start_packet     <= {delay_type_valid && delay_type == LT_START,
                                 lane_type == LT_START && !lanes_swapped};
            rx_bad_block     <= bad_next;
        end
    end

    always_ff @(posedge clk) begin
        lane_data <= data_next;
        swap_data <= masked[`BASER_DATA_W-1:HALF_W];
    end

    // Two aligned starts back to back would mean a broken realignment
    start_not_repeated: assert property (@(posedge clk) disable iff (reset_crc)
        lane_type == LT_START |=> lane_type != LT_START)
        else $error("lane_type START on two cycles in a row");

endmodule

`default_nettype wire

//--- baser_coding_pkg.sv
// Covers only the 64b/66b block types used by 10GBASE-R clause 49 and no ordered-set payloads
`default_nettype none
`include "baser_rx_macros.svh"

package baser_coding_pkg;

    typedef logic [`BASER_HDR_W-1:0] sync_hdr_t;

    localparam sync_hdr_t SYNC_DATA = 2'b10;
    localparam sync_hdr_t SYNC_CTRL = 2'b01;

    // Block type field sits in the first byte of a control block
    typedef enum logic [7:0] {
        BT_CTRL     = 8'h1e,
        BT_OS_4     = 8'h2d,
        BT_START_4  = 8'h33,
        BT_OS_START = 8'h66,
        BT_OS_04    = 8'h55,
        BT_START_0  = 8'h78,
        BT_OS_0     = 8'h4b,
        BT_TERM_0   = 8'h87,  // No data bytes before the terminate
        BT_TERM_1   = 8'h99,
        BT_TERM_2   = 8'haa,
        BT_TERM_3   = 8'hb4,
        BT_TERM_4   = 8'hcc,
        BT_TERM_5   = 8'hd2,
        BT_TERM_6   = 8'he1,
        BT_TERM_7   = 8'hff   // Seven data bytes then the terminate
    } block_type_t;

endpackage

`default_nettype wire

//--- baser_frame_pkg.sv
// Receiver-internal encodings which assume the word has already been realigned to lane 0
`default_nettype none
`include "baser_rx_macros.svh"

package baser_frame_pkg;

    // Bit 3 marks a terminate and the low three bits count its data bytes
    typedef enum logic [3:0] {
        LT_IDLE   = 4'd0,
        LT_ERROR  = 4'd1,
        LT_START  = 4'd2,
        LT_DATA   = 4'd4,
        LT_TERM_0 = 4'd8,
        LT_TERM_1 = 4'd9,
        LT_TERM_2 = 4'd10,
        LT_TERM_3 = 4'd11,
        LT_TERM_4 = 4'd12,
        LT_TERM_5 = 4'd13,
        LT_TERM_6 = 4'd14,
        LT_TERM_7 = 4'd15
    } lane_type_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PAYLOAD,
        ST_LAST
    } framer_state_t;

    // CRC state expected when the FCS ends in byte i and the bytes above it are zero
    localparam logic [`BASER_CRC_W-1:0] fcs_residue [`BASER_KEEP_W] = '{
        ~32'h6b87b1ec,
        ~32'he38a6876,
        ~32'he60914ae,
        ~32'h6522df69,
        ~32'h9d6cdf7e,
        ~32'hb1c2a1a3,
        ~32'hc622f71d,
        ~32'h2144df1c
    };

endpackage

`default_nettype wire

//--- baser_rx_framer.sv
// Opens a frame only on an aligned start while cfg_rx_enable is high and strips the FCS
`timescale 1ns/10ps
`default_nettype none
`include "baser_rx_macros.svh"

module baser_rx_framer (
    input  wire logic                        clk,
    input  wire logic                        reset_crc,
    input  wire logic                        cfg_rx_enable,
    input  wire logic [`BASER_DATA_W-1:0]    lane_data,
    input  wire baser_frame_pkg::lane_type_t lane_type,
    input  wire logic [`BASER_KEEP_W-1:0]    crc_match,
    input  wire logic [`BASER_KEEP_W-1:0]    crc_match_save,
    output logic                             crc_init,
    output logic [`BASER_DATA_W-1:0]         rx_tdata,
    output logic [`BASER_KEEP_W-1:0]         rx_tkeep,
    output logic                             rx_tvalid,
    output logic                             rx_tlast,
    output logic                             rx_tuser,
    output logic                             error_bad_frame,
    output logic                             error_bad_fcs
);
    import baser_frame_pkg::*;

    framer_state_t            state;
    framer_state_t            state_next;
    logic [`BASER_DATA_W-1:0] lane_data_d1;
    lane_type_t               lane_type_d1;
    logic [2:0]               term_sel;
    logic [2:0]               match_idx;
    logic                     fcs_ok;
    logic [`BASER_KEEP_W-1:0] keep_next;
    logic                     valid_next;
    logic                     last_next;
    logic                     user_next;
    logic                     bad_frame_next;
    logic                     bad_fcs_next;

    always_comb begin
        term_sel  = (state == ST_LAST) ? lane_type_d1[2:0] : lane_type[2:0];
        match_idx = term_sel - 3'd1;  // Position of the last FCS byte
        // The FCS ended in the word before when it spills past the current one
        if (term_sel == 3'd0 || state == ST_LAST) begin
            fcs_ok = crc_match_save[match_idx];
        end else begin
            fcs_ok = crc_match[match_idx];
        end
    end

    always_comb begin
        state_next     = ST_IDLE;
        crc_init       = 1'b0;
        keep_next      = '0;
        valid_next     = 1'b0;
        last_next      = 1'b0;
        user_next      = 1'b0;
        bad_frame_next = 1'b0;
        bad_fcs_next   = 1'b0;
        case (state)
            ST_IDLE: begin
                crc_init = 1'b1;
                if (lane_type_d1 == LT_START && cfg_rx_enable) begin
                    crc_init   = 1'b0;
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                keep_next  = '1;
                valid_next = 1'b1;
                if (lane_type == LT_DATA) begin
                    state_next = ST_PAYLOAD;
                end else if (lane_type[3]) begin
                    crc_init = 1'b1;
                    if (term_sel <= 3'd4) begin
                        keep_next      = {`BASER_KEEP_W{1'b1}} >> (3'd4 - term_sel);
                        last_next      = 1'b1;
                        user_next      = !fcs_ok;
                        bad_frame_next = !fcs_ok;
                        bad_fcs_next   = !fcs_ok;
                    end else begin
                        state_next = ST_LAST;  // FCS reaches into the next word
                    end
                end else begin
                    // Control or error block inside the frame
                    crc_init       = 1'b1;
                    last_next      = 1'b1;
                    user_next      = 1'b1;
                    bad_frame_next = 1'b1;
                end
            end
            ST_LAST: begin
                crc_init       = 1'b1;
                keep_next      = 8'h07 >> (3'd7 - term_sel);
                valid_next     = 1'b1;
                last_next      = 1'b1;
                user_next      = !fcs_ok;
                bad_frame_next = !fcs_ok;
                bad_fcs_next   = !fcs_ok;
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state           <= ST_IDLE;
            lane_type_d1    <= LT_IDLE;
            rx_tvalid       <= 1'b0;
            rx_tlast        <= 1'b0;
            rx_tuser        <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
        end else begin
            state           <= state_next;
            lane_type_d1    <= lane_type;
            rx_tvalid       <= valid_next;
            rx_tlast        <= last_next;
            rx_tuser        <= user_next;
            error_bad_frame <= bad_frame_next;
            error_bad_fcs   <= bad_fcs_next;
        end
    end

    always_ff @(posedge clk) begin
        lane_data_d1 <= lane_data;
        rx_tdata     <= lane_data_d1;
        rx_tkeep     <= keep_next;
    end

    // Only the last word may be partial and every word starts in lane 0
    tkeep_packed: assert property (@(posedge clk) disable iff (reset_crc)
        rx_tvalid |-> rx_tkeep[0] && (rx_tlast || rx_tkeep == '1))
        else $error("rx_tkeep not packed from lane 0");

endmodule

`default_nettype wire

//--- baser_rx_macros.svh
// Widths are fixed for 10GBASE-R with one 66-bit block per word and are not meant to be changed
`ifndef BASER_RX_MACROS_SVH
`define BASER_RX_MACROS_SVH

// Block payload and sync header
`define BASER_DATA_W 64
`define BASER_HDR_W 2

// One keep bit per payload byte
`define BASER_KEEP_W 8

// Ethernet CRC-32 in reflected Galois form, bit 0 shifts out first
`define BASER_CRC_W 32
`define BASER_CRC_POLY 32'hedb88320

`endif

//--- baser_rx_top.sv
// Takes one block on every clock and has no back-pressure, so the sink must accept every word
`timescale 1ns/10ps
`default_nettype none
`include "baser_rx_macros.svh"

module baser_rx_top (
    input  wire logic                        clk,
    input  wire logic                        reset_crc,
    input  wire logic [`BASER_DATA_W-1:0]    encoded_rx_data,
    input  wire baser_coding_pkg::sync_hdr_t encoded_rx_hdr,
    input  wire logic                        cfg_rx_enable,
    output wire logic [`BASER_DATA_W-1:0]    rx_tdata,
    output wire logic [`BASER_KEEP_W-1:0]    rx_tkeep,
    output wire logic                        rx_tvalid,
    output wire logic                        rx_tlast,
    output wire logic                        rx_tuser,
    output wire logic [1:0]                  start_packet,
    output wire logic                        error_bad_frame,
    output wire logic                        error_bad_fcs,
    output wire logic                        rx_bad_block
);
    import baser_frame_pkg::*;

    logic [`BASER_DATA_W-1:0] lane_data;  // Realigned to lane 0
    lane_type_t               lane_type;
    logic                     crc_init;
    logic [`BASER_KEEP_W-1:0] crc_match;
    logic [`BASER_KEEP_W-1:0] crc_match_save;

    baser_block_decoder decoder_i (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .encoded_rx_data (encoded_rx_data),
        .encoded_rx_hdr  (encoded_rx_hdr),
        .lane_data       (lane_data),
        .lane_type       (lane_type),
        .start_packet    (start_packet),
        .rx_bad_block    (rx_bad_block)
    );

    eth_fcs_checker fcs_i (
        .clk            (clk),
        .crc_init       (crc_init),
        .lane_data      (lane_data),
        .crc_match      (crc_match),
        .crc_match_save (crc_match_save)
    );

    baser_rx_framer framer_i (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .cfg_rx_enable   (cfg_rx_enable),
        .lane_data       (lane_data),
        .lane_type       (lane_type),
        .crc_match       (crc_match),
        .crc_match_save  (crc_match_save),
        .crc_init        (crc_init),
        .rx_tdata        (rx_tdata),
        .rx_tkeep        (rx_tkeep),
        .rx_tvalid       (rx_tvalid),
        .rx_tlast        (rx_tlast),
        .rx_tuser        (rx_tuser),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs)
    );

endmodule

`default_nettype wire

//--- eth_fcs_checker.sv
// Runs the CRC over whole words, so bytes after a terminate must arrive already masked to zero
`timescale 1ns/10ps
`default_nettype none
`include "baser_rx_macros.svh"

module eth_fcs_checker (
    input  wire logic                     clk,
    input  wire logic                     crc_init,
    input  wire logic [`BASER_DATA_W-1:0] lane_data,
    output logic [`BASER_KEEP_W-1:0]      crc_match,
    output logic [`BASER_KEEP_W-1:0]      crc_match_save
);
    import baser_frame_pkg::*;

    logic [`BASER_CRC_W-1:0] crc_state;
    logic [`BASER_CRC_W-1:0] crc_next;

    // Reflected CRC, data taken LSB first with no final inversion
    function automatic logic [`BASER_CRC_W-1:0] crc_step(
        input logic [`BASER_CRC_W-1:0]  state,
        input logic [`BASER_DATA_W-1:0] data
    );
        logic [`BASER_CRC_W-1:0] crc;
        crc = state;
        for (int i = 0; i < `BASER_DATA_W; i++) begin
            if (crc[0] ^ data[i]) begin
                crc = (crc >> 1) ^ `BASER_CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        return crc;
    endfunction

    always_comb begin
        crc_next = crc_step(crc_state, lane_data);
        // One compare per possible position of the last FCS byte
        for (int i = 0; i < `BASER_KEEP_W; i++) begin
            crc_match[i] = crc_next == fcs_residue[i];
        end
    end

    always_ff @(posedge clk) begin
        crc_state      <= crc_init ? '1 : crc_next;
        crc_match_save <= crc_match;  // For terminates decided a word later
    end

    // A freshly loaded state gives defined matches for the first word
    crc_init_gives_known_match: assert property (@(posedge clk)
        crc_init |=> !$isunknown(crc_match))
        else $error("CRC match unknown after crc_init");

endmodule

`default_nettype wire

//--- project.f
+incdir+.
baser_coding_pkg.sv
baser_frame_pkg.sv
baser_block_decoder.sv
eth_fcs_checker.sv
baser_rx_framer.sv
baser_rx_top.sv
tb_baser_rx.sv

//--- tb_baser_rx.sv
// Sends four or more idle blocks between frames and expects the FCS stripped from every frame
`timescale 1ns/10ps
`default_nettype none
`include "baser_rx_macros.svh"

module tb_baser_rx;
    import baser_coding_pkg::*;

    localparam int TIMEOUT = 100;
    localparam logic [`BASER_DATA_W-1:0] IDLE_BLOCK = {56'h0, BT_CTRL};
    localparam block_type_t TERM_CODES [8] = '{BT_TERM_0, BT_TERM_1, BT_TERM_2, BT_TERM_3,
                                               BT_TERM_4, BT_TERM_5, BT_TERM_6, BT_TERM_7};

    logic                     clk = 1'b0;
    logic                     reset_crc;
    logic [`BASER_DATA_W-1:0] encoded_rx_data;
    sync_hdr_t                encoded_rx_hdr;
    logic                     cfg_rx_enable;
    logic [`BASER_DATA_W-1:0] rx_tdata;
    logic [`BASER_KEEP_W-1:0] rx_tkeep;
    logic                     rx_tvalid;
    logic                     rx_tlast;
    logic                     rx_tuser;
    logic [1:0]               start_packet;
    logic                     error_bad_frame;
    logic                     error_bad_fcs;
    logic                     rx_bad_block;

    int                       errors = 0;
    int                       starts_lane0 = 0;
    int                       starts_lane4 = 0;
    int                       bad_blocks = 0;
    logic [31:0]              rand_state = 32'd11215;
    logic [7:0]               frame_buf [0:127];  // Payload followed by the FCS
    logic [`BASER_DATA_W-1:0] exp_data_q [$];
    logic [`BASER_KEEP_W-1:0] exp_keep_q [$];
    logic [2:0]               exp_flags_q [$];    // Last, user, bad FCS

    baser_rx_top dut_i (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .encoded_rx_data (encoded_rx_data),
        .encoded_rx_hdr  (encoded_rx_hdr),
        .cfg_rx_enable   (cfg_rx_enable),
        .rx_tdata        (rx_tdata),
        .rx_tkeep        (rx_tkeep),
        .rx_tvalid       (rx_tvalid),
        .rx_tlast        (rx_tlast),
        .rx_tuser        (rx_tuser),
        .start_packet    (start_packet),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs),
        .rx_bad_block    (rx_bad_block)
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[30:15];
    endfunction

    // Ethernet CRC-32 over the first n bytes, byte 0 of the result goes out first
    function automatic logic [31:0] fcs_of(input int n);
        logic [31:0] crc;
        crc = 32'hffffffff;
        for (int i = 0; i < n; i++) begin
            crc = crc ^ {24'h0, frame_buf[i]};
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? (crc >> 1) ^ 32'hedb88320 : crc >> 1;
            end
        end
        return ~crc;
    endfunction

    function automatic logic [`BASER_KEEP_W-1:0] keep_for(input int n);
        return 8'hff >> (8 - n);
    endfunction

    function automatic logic [`BASER_DATA_W-1:0] pack_word(input int base, input int n);
        logic [`BASER_DATA_W-1:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = frame_buf[base + i];
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_quiet();
        check_value("rx_tvalid", rx_tvalid, 0);
        check_value("start_packet", start_packet, 0);
        check_value("error_bad_frame", error_bad_frame, 0);
        check_value("error_bad_fcs", error_bad_fcs, 0);
        check_value("rx_bad_block", rx_bad_block, 0);
    endtask

    // Output words for the first nbytes of frame_buf
    task automatic expect_words(input int nbytes, input bit user, input bit fcs_bad);
        int  n;
        bit  last;
        for (int base = 0; base < nbytes; base += 8) begin
            n    = (nbytes - base >= 8) ? 8 : nbytes - base;
            last = base + n == nbytes;
            exp_data_q.push_back(pack_word(base, n));
            exp_keep_q.push_back(keep_for(n));
            exp_flags_q.push_back({last, user && last, fcs_bad && last});
        end
    endtask

    task automatic send_block(input sync_hdr_t hdr, input logic [`BASER_DATA_W-1:0] data);
        @(negedge clk);
        encoded_rx_hdr  = hdr;
        encoded_rx_data = data;
    endtask

    task automatic send_idle();
        send_block(SYNC_CTRL, IDLE_BLOCK);
    endtask

    task automatic send_frame(input int len, input int lane, input int abort_after,
                              input bit bad_fcs);
        logic [7:0]               wire_q [$];
        logic [31:0]              fcs;
        logic [`BASER_DATA_W-1:0] blk;
        int                       nblk;
        fcs = fcs_of(len - 4);
        for (int i = 0; i < 4; i++) begin
            frame_buf[len - 4 + i] = fcs[8*i +: 8];
        end
        if (bad_fcs) begin
            frame_buf[len - 2] = ~frame_buf[len - 2];
        end
        if (lane == 4) begin
            wire_q = '{8'h55, 8'h55, 8'h55, 8'hd5};  // Preamble tail spills into the next block
            send_block(SYNC_CTRL, {24'h555555, 32'h0, BT_START_4});
        end else begin
            send_block(SYNC_CTRL, {8'hd5, {6{8'h55}}, BT_START_0});
        end
        for (int i = 0; i < len; i++) begin
            wire_q.push_back(frame_buf[i]);
        end
        nblk = 0;
        while (wire_q.size() >= 8) begin
            for (int i = 0; i < 8; i++) begin
                blk[8*i +: 8] = wire_q.pop_front();
            end
            if (nblk == abort_after) begin
                send_block(SYNC_CTRL, IDLE_BLOCK);
                return;
            end
            send_block(SYNC_DATA, blk);
            nblk++;
        end
        blk      = '0;
        blk[7:0] = TERM_CODES[wire_q.size()];
        for (int i = 1; wire_q.size() != 0; i++) begin
            blk[8*i +: 8] = wire_q.pop_front();
        end
        send_block(SYNC_CTRL, blk);
    endtask

    task automatic run_frame(input int len, input int lane, input int abort_after,
                             input bit bad_fcs, input bit fresh);
        int s0;
        int s4;
        int cycles;
        s0 = starts_lane0;
        s4 = starts_lane4;
        if (fresh) begin
            for (int i = 0; i < len - 4; i++) begin
                frame_buf[i] = 8'(next_rand());
            end
        end
        if (cfg_rx_enable && abort_after >= 0) begin
            expect_words(8 * abort_after, 1'b1, 1'b0);
        end else if (cfg_rx_enable) begin
            expect_words(len - 4, bad_fcs, bad_fcs);
        end
        send_frame(len, lane, abort_after, bad_fcs);
        cycles = 0;
        while ((exp_data_q.size() != 0 || starts_lane0 + starts_lane4 == s0 + s4)
               && cycles < TIMEOUT) begin
            send_idle();
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            errors++;
            $display("timeout: frame of %0d bytes did not come out of the receiver", len);
            exp_data_q.delete();
            exp_keep_q.delete();
            exp_flags_q.delete();
        end
        repeat (4) send_idle();  // Lets a delayed terminate clear
        check_value("start_packet[0] pulses", starts_lane0 - s0, lane == 0);
        check_value("start_packet[1] pulses", starts_lane4 - s4, lane == 4);
    endtask

    // Outputs are registered, so the falling edge sees settled values
    always @(negedge clk) begin : monitor
        logic [`BASER_DATA_W-1:0] mask;
        logic [`BASER_KEEP_W-1:0] keep;
        logic [2:0]               flags;
        if (!reset_crc) begin
            starts_lane0 += start_packet[0];
            starts_lane4 += start_packet[1];
            bad_blocks   += rx_bad_block;
            if (rx_tvalid && exp_data_q.size() == 0) begin
                errors++;
                $display("receiver put out a word 0x%h with no frame expected", rx_tdata);
            end else if (rx_tvalid) begin
                keep  = exp_keep_q.pop_front();
                flags = exp_flags_q.pop_front();
                for (int i = 0; i < 8; i++) begin
                    mask[8*i +: 8] = {8{keep[i]}};
                end
                check_value("rx_tdata", rx_tdata & mask, exp_data_q.pop_front());
                check_value("rx_tkeep", rx_tkeep, keep);
                check_value("rx_tlast", rx_tlast, flags[2]);
                check_value("rx_tuser", rx_tuser, flags[1]);
                check_value("error_bad_frame", error_bad_frame, flags[1]);
                check_value("error_bad_fcs", error_bad_fcs, flags[0]);
            end else begin
                check_value("rx_tlast", rx_tlast, 0);
                check_value("error_bad_frame", error_bad_frame, 0);
                check_value("error_bad_fcs", error_bad_fcs, 0);
            end
        end
    end

    initial begin
        int len;
        int cycles;
        reset_crc       = 1'b1;
        cfg_rx_enable   = 1'b1;
        encoded_rx_hdr  = SYNC_CTRL;
        encoded_rx_data = IDLE_BLOCK;
        @(negedge clk);
        check_quiet();
        @(negedge clk);
        reset_crc = 1'b0;
        repeat (6) begin
            send_idle();
            check_quiet();
        end

        // All terminate offsets in lane 0, then the same payload started in lane 4
        for (int t = 0; t < 8; t++) begin
            len = 64 + 8 * (next_rand() % 4) + t;
            run_frame(len, 0, -1, 1'b0, 1'b1);
            run_frame(len, 4, -1, 1'b0, 1'b0);
        end
        run_frame(70, 0, -1, 1'b1, 1'b1);
        run_frame(67, 4, -1, 1'b1, 1'b1);
        run_frame(90, 0, 3, 1'b0, 1'b1);  // Control block after three data blocks
        run_frame(77, 0, -1, 1'b0, 1'b1);

        send_block(2'b00, IDLE_BLOCK);
        cycles = 0;
        while (bad_blocks == 0 && cycles < TIMEOUT) begin
            send_idle();
            cycles++;
        end
        if (bad_blocks == 0) begin
            errors++;
            $display("rx_bad_block never pulsed after a block with sync header 00");
        end

        cfg_rx_enable = 1'b0;
        run_frame(64 + next_rand() % 37, 0, -1, 1'b0, 1'b1);
        run_frame(64 + next_rand() % 37, 4, -1, 1'b0, 1'b1);
        cfg_rx_enable = 1'b1;
        run_frame(64 + next_rand() % 37, 0, -1, 1'b0, 1'b1);
        run_frame(64 + next_rand() % 37, 4, -1, 1'b0, 1'b1);
        check_value("rx_bad_block pulses", bad_blocks, 1);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
